// File: mmuTop.f
+incdir+common
common/mmuPkg.sv
tlb/tlbArray.sv
tlb/tlbMatch.sv
hdl/tlbMaint.sv
hdl/addrTranslate.sv
hdl/mmuTop.sv
tests/mmuTop_tb.sv

// File: run.sh
#!/bin/sh
# build and run the MMU testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module mmuTop_tb -f mmuTop.f -o mmuSim \
    || { echo "build failed"; exit 1; }
./obj_dir/mmuSim > sim.log 2>&1
cat sim.log
grep -qx "Test passed" sim.log && echo "simulation ok" && exit 0 \
    || { echo "simulation reported failure"; exit 1; }

// File: tests/mmuTop_tb.sv
`timescale 1ns/100ps
`include "mmu_consts.svh"

module mmuTop_tb;
    import mmuPkg::*;

    logic clk = 1'b0;
    logic rstN;
    logic [3:0] instType;
    logic [4:0] subtype, invOpIn;
    logic stallW, flushW;
    logic [31:0] tlbIdxIn, tlbEhiIn, tlbElo0In, tlbElo1In;
    logic [31:0] tlbIdxOut, tlbEhiOut, tlbElo0Out, tlbElo1Out;
    logic [`ASID_W-1:0] asidOut, asid;
    logic [8:0] crmd;
    logic stall0, flush0, vaddrValid0, paddrValid0;
    logic stall1, flush1, vaddrValid1, paddrValid1;
    logic [1:0] opType0, opType1, memType0, memType1;
    logic [31:0] vaddr0, vaddr1, paddr0, paddr1;
    excpArgT excpArg0, excpArg1;

    // reference copy of the TLB
    logic [`VPPN_W-1:0] refVppn [`TLB_ENTRIES];
    logic [`ASID_W-1:0] refAsid [`TLB_ENTRIES];
    logic [31:0]        refElo0 [`TLB_ENTRIES];
    logic [31:0]        refElo1 [`TLB_ENTRIES];
    logic               refE    [`TLB_ENTRIES];

    logic [31:0] seed = 32'd17237;
    int errCount = 0;
    int testErrStart = 0;
    int testCount = 0;
    int failedTests = 0;

    mmuTop mmuTop_i (.*);

    always #10 clk = ~clk;

    // a stalled port keeps its result
    // flush on port 0 wins over stall
    stallHold0: assert property (@(posedge clk) disable iff (!rstN)
        (stall0 && !flush0) |=> $stable({paddrValid0, paddr0, excpArg0, memType0}))
        else
        begin
            errCount++;
            $display("error at %0t ns: port 0 changed while stalled", $time);
        end
    stallHold1: assert property (@(posedge clk) disable iff (!rstN)
        stall1 |=> $stable({paddrValid1, paddr1, excpArg1, memType1}))
        else
        begin
            errCount++;
            $display("error at %0t ns: port 1 changed while stalled", $time);
        end
    flushClr0: assert property (@(posedge clk) disable iff (!rstN)
        flush0 |=> ({paddrValid0, paddr0, excpArg0, memType0} == '0))
        else
        begin
            errCount++;
            $display("error at %0t ns: port 0 not cleared by flush", $time);
        end
    flushClr1: assert property (@(posedge clk) disable iff (!rstN)
        (flush1 && !stall1) |=> ({paddrValid1, paddr1, excpArg1, memType1} == '0))
        else
        begin
            errCount++;
            $display("error at %0t ns: port 1 not cleared by flush", $time);
        end

    function automatic logic [31:0] lcgNext();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    task automatic checkVal(input string what, input logic [159:0] got,
                            input logic [159:0] exp);
        assert (got === exp)
        else
        begin
            errCount++;
            $display("error at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic finishTest(input string name);
        int errs;
        errs = errCount - testErrStart;
        testCount++;
        if (errs != 0)
            failedTests++;
        $display("test %0d %s: %s (%0d errors)", testCount, name, errs ? "FAIL" : "ok", errs);
        testErrStart = errCount;
    endtask

    // expected translation in exception priority order
    task automatic predict(input logic [31:0] va, input logic [1:0] op, input logic vv,
                           output logic v, output logic [31:0] pa,
                           output logic [15:0] ex, output logic [1:0] mt);
        logic [1:0] lv;
        logic hit;
        logic [31:0] elo;
        lv  = crmd[1:0];
        hit = 1'b0;
        elo = '0;
        v   = 1'b0;
        pa  = '0;
        ex  = '0;
        mt  = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++)
        begin
            if (refE[i] && refVppn[i] == va[31:13] &&
                ((refElo0[i][6] && refElo1[i][6]) || refAsid[i] == asid))
            begin
                hit = 1'b1;
                elo = va[12] ? refElo1[i] : refElo0[i];
            end
        end
        if (crmd[3] && !crmd[4])
        begin
            v  = vv;
            pa = va;
            mt = (op == `ACC_FETCH) ? crmd[6:5] : crmd[8:7];
        end
        else if (lv != 2'd0 && va[31])
            ex = {vv, (op == `ACC_FETCH) ? `ESUB_ADEF : `ESUB_ADEM, `EC_ADE};
        else if (!hit)
            ex = {vv, 9'h0, `EC_TLBR};
        else if (!elo[0])
            ex = {vv, 9'h0, (op == `ACC_FETCH) ? `EC_PIF : (op == `ACC_LOAD) ? `EC_PIL : `EC_PIS};
        else if (lv > elo[3:2])
            ex = {vv, 9'h0, `EC_PPI};
        else if (op == `ACC_STORE && !elo[1])
            ex = {vv, 9'h0, `EC_PME};
        else
        begin
            v  = vv;
            pa = {elo[27:8], va[11:0]};
            mt = elo[5:4];
        end
    endtask

    task automatic checkPort(input int p, input logic [31:0] va, input logic [1:0] op,
                             input logic vv);
        logic v;
        logic [31:0] pa;
        logic [15:0] ex;
        logic [1:0] mt;
        predict(va, op, vv, v, pa, ex, mt);
        checkVal($sformatf("port%0d valid va %h", p, va), p ? paddrValid1 : paddrValid0, v);
        checkVal($sformatf("port%0d excp va %h", p, va), p ? excpArg1 : excpArg0, ex);
        if (ex == '0)
        begin
            checkVal($sformatf("port%0d paddr", p), p ? paddr1 : paddr0, pa);
            checkVal($sformatf("port%0d memType", p), p ? memType1 : memType0, mt);
        end
    endtask

    // both ports issue in the same cycle
    // result checked one cycle later
    task automatic lookupPair(input logic [31:0] va0, input logic [1:0] op0,
                              input logic [31:0] va1, input logic [1:0] op1, input logic vv1);
        vaddr0      = va0;
        opType0     = op0;
        vaddrValid0 = 1'b1;
        vaddr1      = va1;
        opType1     = op1;
        vaddrValid1 = vv1;
        @(negedge clk);
        checkPort(0, va0, op0, 1'b1);
        checkPort(1, va1, op1, vv1);
    endtask

    task automatic maintOp(input logic [4:0] op);
        instType = `TYPE_MMU;
        subtype  = op;
        @(negedge clk);
        instType = 4'd0;
        subtype  = 5'd0;
    endtask

    function automatic logic [31:0] makeElo(input logic g, input logic [1:0] plv,
                                            input logic d, input logic v);
        logic [31:0] r;
        r = lcgNext();
        return {4'b0, r[27:8], 1'b0, g, r[5:4], plv, d, v};
    endfunction

    task automatic writeEntry(input int idx, input logic [31:0] elo0, input logic [31:0] elo1,
                              input logic fill);
        logic [31:0] r;
        r = lcgNext();
        refVppn[idx] = {1'b0, r[20:8], idx[4:0]};  // low bits unique per slot
        refAsid[idx] = asid;
        refElo0[idx] = elo0;
        refElo1[idx] = elo1;
        refE[idx]    = 1'b1;
        tlbIdxIn  = {27'b0, idx[4:0]};
        tlbEhiIn  = {refVppn[idx], 13'b0};
        tlbElo0In = elo0;
        tlbElo1In = elo1;
        maintOp(fill ? `OP_TLBFILL : `OP_TLBWR);
    endtask

    task automatic invalidate(input logic [1:0] op);
        for (int i = 0; i < `TLB_ENTRIES; i++)
        begin
            if (op <= 2'd1 || (op == 2'd2) == (refElo0[i][6] && refElo1[i][6]))
                refE[i] = 1'b0;
        end
        invOpIn = {3'b0, op};
        maintOp(`OP_INVTLB);
        invOpIn = '0;
    endtask

    // even page on port 0, odd page on port 1
    task automatic checkEntries(input int count);
        logic [31:0] r;
        for (int i = 0; i < count; i++)
        begin
            r = lcgNext();
            lookupPair({refVppn[i], 1'b0, r[11:0]}, `ACC_LOAD,
                       {refVppn[i], 1'b1, r[23:12]}, `ACC_FETCH, 1'b1);
        end
    endtask

    initial
    begin
        #2_000_000;
        $display("simulation timed out");
        $display("Test failed");
        $finish;
    end

    initial
    begin
        logic [31:0] r;
        logic [31:0] held;
        for (int i = 0; i < `TLB_ENTRIES; i++)
            refE[i] = 1'b0;
        rstN = 1'b0;
        {instType, subtype, invOpIn, stallW, flushW} = '0;
        {tlbIdxIn, tlbEhiIn, tlbElo0In, tlbElo1In} = '0;
        crmd = '0;
        asid = 10'h05;
        {stall0, flush0, opType0, vaddrValid0, vaddr0} = '0;
        {stall1, flush1, opType1, vaddrValid1, vaddr1} = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        checkVal("reset valids", {paddrValid0, paddrValid1}, 2'b0);
        checkVal("reset port 0", {paddr0, excpArg0, memType0}, '0);
        checkVal("reset port 1", {paddr1, excpArg1, memType1}, '0);
        checkVal("reset maint", {tlbIdxOut, tlbEhiOut, tlbElo0Out, tlbElo1Out, asidOut}, '0);
        finishTest("reset");

        crmd = 9'b01_10_0_1_0_00;  // DA, datf 2, datm 1
        for (int k = 0; k < 4; k++)
            lookupPair(lcgNext(), `ACC_FETCH, lcgNext(), 2'(k % 3), k[0]);
        held = paddr0;
        stall0 = 1'b1;
        stall1 = 1'b1;
        vaddr0 = lcgNext();
        vaddr1 = lcgNext();
        @(negedge clk);
        checkVal("stalled paddr0", paddr0, held);
        held = paddr1;
        flush0 = 1'b1;
        flush1 = 1'b1;
        @(negedge clk);
        checkVal("flushed port 0", {paddrValid0, paddr0}, '0);
        checkVal("port 1 flush under stall", paddr1, held);
        stall0 = 1'b0;
        stall1 = 1'b0;
        @(negedge clk);
        checkVal("flushed port 1", {paddrValid1, paddr1}, '0);
        flush0 = 1'b0;
        flush1 = 1'b0;
        finishTest("direct mode");

        crmd = {4'b0, 1'b1, 2'b00, 2'd0};  // paged, plv 0
        for (int i = 0; i < 8; i++)
            writeEntry(i, makeElo(!i[0], 2'd3, 1'b1, 1'b1), makeElo(!i[0], 2'd3, 1'b1, 1'b1), i[1]);
        checkEntries(8);
        asid = 10'h2A3;
        checkEntries(8);
        asid = 10'h05;
        finishTest("mapped translation");

        writeEntry(8, makeElo(1'b0, 2'd0, 1'b1, 1'b0), makeElo(1'b0, 2'd0, 1'b0, 1'b1), 1'b0);
        r = lcgNext();
        lookupPair({refVppn[8], 1'b0, r[11:0]}, `ACC_FETCH,
                   {refVppn[8], 1'b0, r[23:12]}, `ACC_LOAD, 1'b1);
        lookupPair({refVppn[8], 1'b0, r[11:0]}, `ACC_STORE,
                   {refVppn[8], 1'b1, r[23:12]}, `ACC_STORE, 1'b1);
        lookupPair({1'b0, r[20:8], 5'd31, r[12:0]}, `ACC_LOAD,
                   {refVppn[8], 1'b1, r[11:0]}, `ACC_LOAD, 1'b1);
        crmd[1:0] = 2'd3;
        lookupPair({refVppn[8], 1'b1, r[11:0]}, `ACC_LOAD,
                   {refVppn[8], 1'b1, r[23:12]}, `ACC_FETCH, 1'b1);
        lookupPair({1'b1, r[30:0]}, `ACC_FETCH, {1'b1, r[31:1]}, `ACC_LOAD, 1'b1);
        checkVal("ADEF code", excpArg0, {1'b1, `ESUB_ADEF, `EC_ADE});
        checkVal("ADEM code", excpArg1, {1'b1, `ESUB_ADEM, `EC_ADE});
        crmd[1:0] = 2'd0;
        finishTest("exceptions");

        for (int i = 0; i < 8; i++)
        begin
            tlbEhiIn = {refVppn[i], 13'b0};
            maintOp(`OP_TLBSRCH);
            checkVal("srch NE", tlbIdxOut[`IDX_NE], 1'b0);
            checkVal("srch index", tlbIdxOut[4:0], i[4:0]);
            tlbIdxIn = {27'b0, i[4:0]};
            tlbEhiIn = '0;
            maintOp(`OP_TLBRD);
            checkVal("rd index", tlbIdxOut, {2'b0, 6'd12, 19'b0, i[4:0]});
            checkVal("rd ehi", tlbEhiOut, {refVppn[i], 13'b0});
            checkVal("rd elo0", tlbElo0Out, refElo0[i]);
            checkVal("rd elo1", tlbElo1Out, refElo1[i]);
            checkVal("rd asid", asidOut, refAsid[i]);
        end
        tlbEhiIn = {1'b0, 13'h1ABC, 5'd30, 13'b0};  // slot 30 never written
        maintOp(`OP_TLBSRCH);
        checkVal("srch miss NE", tlbIdxOut[`IDX_NE], 1'b1);
        tlbIdxIn = 32'd31;
        maintOp(`OP_TLBRD);
        checkVal("rd invalid", {tlbIdxOut, tlbEhiOut, tlbElo0Out, tlbElo1Out, asidOut},
                 {1'b1, 31'b0, 96'b0, 10'b0});
        finishTest("search and read");

        invalidate(2'd2);
        checkEntries(8);
        for (int i = 0; i < 8; i++)
            writeEntry(i, refElo0[i], refElo1[i], 1'b0);
        invalidate(2'd3);
        checkEntries(8);
        invalidate(2'd0);
        checkEntries(9);
        finishTest("invalidate");

        $display("%0d tests, %0d failed, %0d errors", testCount, failedTests, errCount);
        if (errCount == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: hdl/mmuTop.sv
`timescale 1ns/100ps
`include "mmu_consts.svh"

module mmuTop
(
    input  logic               clk,
    input  logic               rstN,
    input  logic [3:0]         instType,
    input  logic [4:0]         subtype,
    input  logic [4:0]         invOpIn,
    input  logic               stallW,
    input  logic               flushW,
    input  logic [31:0]        tlbIdxIn,
    input  logic [31:0]        tlbEhiIn,
    input  logic [31:0]        tlbElo0In,
    input  logic [31:0]        tlbElo1In,
    output logic [31:0]        tlbIdxOut,
    output logic [31:0]        tlbEhiOut,
    output logic [31:0]        tlbElo0Out,
    output logic [31:0]        tlbElo1Out,
    output logic [`ASID_W-1:0] asidOut,
    input  logic [8:0]         crmd,
    input  logic [`ASID_W-1:0] asid,
    input  logic               stall0,
    input  logic               flush0,
    input  logic [1:0]         opType0,  // 0 fetch, 1 load, 2 store
    input  logic               vaddrValid0,
    input  logic [31:0]        vaddr0,
    output logic               paddrValid0,
    output logic [31:0]        paddr0,
    output mmuPkg::excpArgT    excpArg0,
    output logic [1:0]         memType0,
    input  logic               stall1,
    input  logic               flush1,
    input  logic [1:0]         opType1,
    input  logic               vaddrValid1,
    input  logic [31:0]        vaddr1,
    output logic               paddrValid1,
    output logic [31:0]        paddr1,
    output mmuPkg::excpArgT    excpArg1,
    output logic [1:0]         memType1
);
    import mmuPkg::*;

    tlbTableT              entries;
    tlbEntryT              rdEntry;
    tlbEntryT              wrEntry;
    logic [`TLB_IDX_W-1:0] index;
    logic                  wrEn;
    logic                  invEn;
    logic [1:0]            invOp;

    tlbArray tlbArray_i
    (
        .clk     (clk),
        .rstN    (rstN),
        .index   (index),
        .wrEn    (wrEn),
        .wrEntry (wrEntry),
        .invEn   (invEn),
        .invOp   (invOp),
        .entries (entries),
        .rdEntry (rdEntry)
    );

    tlbMaint tlbMaint_i
    (
        .clk        (clk),
        .rstN       (rstN),
        .instType   (instType),
        .subtype    (subtype),
        .invOpIn    (invOpIn),
        .stallW     (stallW),
        .flushW     (flushW),
        .asid       (asid),
        .tlbIdxIn   (tlbIdxIn),
        .tlbEhiIn   (tlbEhiIn),
        .tlbElo0In  (tlbElo0In),
        .tlbElo1In  (tlbElo1In),
        .rdEntry    (rdEntry),
        .entries    (entries),
        .index      (index),
        .wrEn       (wrEn),
        .wrEntry    (wrEntry),
        .invEn      (invEn),
        .invOp      (invOp),
        .tlbIdxOut  (tlbIdxOut),
        .tlbEhiOut  (tlbEhiOut),
        .tlbElo0Out (tlbElo0Out),
        .tlbElo1Out (tlbElo1Out),
        .asidOut    (asidOut)
    );

    addrTranslate #(.FLUSH_OVER_STALL(1'b1)) port0_i
    (
        .clk        (clk),
        .rstN       (rstN),
        .stall      (stall0),
        .flush      (flush0),
        .opType     (opType0),
        .vaddrValid (vaddrValid0),
        .vaddr      (vaddr0),
        .crmd       (crmd),
        .asid       (asid),
        .entries    (entries),
        .paddrValid (paddrValid0),
        .paddr      (paddr0),
        .excpArg    (excpArg0),
        .memType    (memType0)
    );

    // flush honoured only when not stalled
    addrTranslate #(.FLUSH_OVER_STALL(1'b0)) port1_i
    (
        .clk        (clk),
        .rstN       (rstN),
        .stall      (stall1),
        .flush      (flush1),
        .opType     (opType1),
        .vaddrValid (vaddrValid1),
        .vaddr      (vaddr1),
        .crmd       (crmd),
        .asid       (asid),
        .entries    (entries),
        .paddrValid (paddrValid1),
        .paddr      (paddr1),
        .excpArg    (excpArg1),
        .memType    (memType1)
    );

endmodule

// File: hdl/addrTranslate.sv
`timescale 1ns/100ps
`include "mmu_consts.svh"

module addrTranslate
#(
    parameter bit FLUSH_OVER_STALL = 1'b1
)
(
    input  logic               clk,
    input  logic               rstN,
    input  logic               stall,
    input  logic               flush,
    input  logic [1:0]         opType,
    input  logic               vaddrValid,
    input  logic [31:0]        vaddr,
    input  logic [8:0]         crmd,
    input  logic [`ASID_W-1:0] asid,
    input  mmuPkg::tlbTableT   entries,
    output logic               paddrValid,
    output logic [31:0]        paddr,
    output mmuPkg::excpArgT    excpArg,
    output logic [1:0]         memType
);
    import mmuPkg::*;

    logic                  tlbHit;
    logic [`TLB_IDX_W-1:0] hitIndex;
    tlbPageT               page;
    logic [1:0]            plv;
    logic                  directMode;
    logic                  fault;
    logic                  flushNow;
    logic [5:0]            piCode;
    logic [31:0]           paddrNext;
    logic [1:0]            memTypeNext;
    excpArgT               excpNext;

    tlbMatch lookMatch_i
    (
        .entries  (entries),
        .vpn      (vaddr[31:`EHI_VPPN_LSB]),
        .asid     (asid),
        .hit      (tlbHit),
        .hitIndex (hitIndex)
    );

    assign page       = vaddr[`PAGE_SHIFT] ? entries[hitIndex].page1 : entries[hitIndex].page0;
    assign plv        = crmd[`CRMD_PLV_HI:`CRMD_PLV_LO];
    assign directMode = crmd[`CRMD_DA_BIT] && !crmd[`CRMD_PG_BIT];
    assign piCode     = (opType == `ACC_FETCH) ? `EC_PIF :
                        (opType == `ACC_LOAD)  ? `EC_PIL : `EC_PIS;

    always_comb
    begin
        paddrNext   = {page.ppn, vaddr[`PAGE_SHIFT-1:0]};
        memTypeNext = page.mat;
        excpNext    = '0;
        fault       = 1'b1;
        if (directMode)
        begin
            fault       = 1'b0;
            paddrNext   = vaddr;
            memTypeNext = (opType == `ACC_FETCH) ? crmd[`CRMD_DATF_HI:`CRMD_DATF_LO]
                                                 : crmd[`CRMD_DATM_HI:`CRMD_DATM_LO];
        end
        else if (plv != 2'd0 && vaddr[31])
            excpNext = {vaddrValid, (opType == `ACC_FETCH) ? `ESUB_ADEF : `ESUB_ADEM, `EC_ADE};
        else if (!tlbHit)
            excpNext = {vaddrValid, 9'h0, `EC_TLBR};
        else if (!page.v)
            excpNext = {vaddrValid, 9'h0, piCode};
        else if (plv > page.plv)
            excpNext = {vaddrValid, 9'h0, `EC_PPI};
        else if (opType == `ACC_STORE && !page.d)
            excpNext = {vaddrValid, 9'h0, `EC_PME};  // clean page store
        else
            fault = 1'b0;
    end

    // port 1 flush waits for the stall to drop
    assign flushNow = flush && (FLUSH_OVER_STALL || !stall);

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            paddrValid <= 1'b0;
            paddr      <= '0;
            excpArg    <= '0;
            memType    <= '0;
        end
        else if (flushNow)
        begin
            paddrValid <= 1'b0;
            paddr      <= '0;
            excpArg    <= '0;
            memType    <= '0;
        end
        else if (!stall)
        begin
            paddrValid <= vaddrValid && !fault;
            paddr      <= paddrNext;
            excpArg    <= excpNext;
            memType    <= memTypeNext;
        end
    end

    validNoExcp: assert property (@(posedge clk) disable iff (!rstN) paddrValid |-> excpArg == '0)
        else $error("valid translation carries an exception");

endmodule

// File: hdl/tlbMaint.sv
`timescale 1ns/100ps
`include "mmu_consts.svh"

module tlbMaint
(
    input  logic                  clk,
    input  logic                  rstN,
    input  logic [3:0]            instType,
    input  logic [4:0]            subtype,
    input  logic [4:0]            invOpIn,
    input  logic                  stallW,
    input  logic                  flushW,
    input  logic [`ASID_W-1:0]    asid,
    input  logic [31:0]           tlbIdxIn,
    input  logic [31:0]           tlbEhiIn,
    input  logic [31:0]           tlbElo0In,
    input  logic [31:0]           tlbElo1In,
    input  mmuPkg::tlbEntryT      rdEntry,
    input  mmuPkg::tlbTableT      entries,
    output logic [`TLB_IDX_W-1:0] index,
    output logic                  wrEn,
    output mmuPkg::tlbEntryT      wrEntry,
    output logic                  invEn,
    output logic [1:0]            invOp,
    output logic [31:0]           tlbIdxOut,
    output logic [31:0]           tlbEhiOut,
    output logic [31:0]           tlbElo0Out,
    output logic [31:0]           tlbElo1Out,
    output logic [`ASID_W-1:0]    asidOut
);
    import mmuPkg::*;

    logic                  isMmu;
    logic                  fire;
    logic                  srchHit;
    logic [`TLB_IDX_W-1:0] srchIndex;
    logic [31:0]           idxNext;
    logic [31:0]           ehiNext;
    logic [31:0]           elo0Next;
    logic [31:0]           elo1Next;
    logic [`ASID_W-1:0]    asidNext;

    function automatic tlbPageT unpackElo(input logic [31:0] elo);
        tlbPageT pg;
        pg.ppn = elo[`ELO_PPN_LSB +: `PPN_W];
        pg.mat = elo[5:4];
        pg.plv = elo[3:2];
        pg.d   = elo[1];
        pg.v   = elo[0];
        return pg;
    endfunction

    function automatic logic [31:0] packElo(input tlbPageT pg, input logic g);
        return {4'b0, pg.ppn, 1'b0, g, pg.mat, pg.plv, pg.d, pg.v};
    endfunction

    assign isMmu = (instType == `TYPE_MMU) || (instType == `TYPE_PRIV_MMU);
    assign fire  = isMmu && !stallW && !flushW;

    assign index = tlbIdxIn[`TLB_IDX_W-1:0];
    assign wrEn  = fire && ((subtype == `OP_TLBWR) || (subtype == `OP_TLBFILL));
    assign invEn = fire && (subtype == `OP_INVTLB) && (invOpIn[4:2] == 3'b0);  // ops 0..3
    assign invOp = invOpIn[1:0];

    assign wrEntry.vppn  = tlbEhiIn[31:`EHI_VPPN_LSB];
    assign wrEntry.asid  = asid;
    assign wrEntry.g     = tlbElo0In[`ELO_G] & tlbElo1In[`ELO_G];
    assign wrEntry.e     = ~tlbIdxIn[`IDX_NE];
    assign wrEntry.page0 = unpackElo(tlbElo0In);
    assign wrEntry.page1 = unpackElo(tlbElo1In);

    tlbMatch srchMatch_i
    (
        .entries  (entries),
        .vpn      (tlbEhiIn[31:`EHI_VPPN_LSB]),
        .asid     (asid),
        .hit      (srchHit),
        .hitIndex (srchIndex)
    );

    always_comb
    begin
        idxNext  = tlbIdxIn;
        ehiNext  = tlbEhiIn;
        elo0Next = tlbElo0In;
        elo1Next = tlbElo1In;
        asidNext = asid;
        if (isMmu && subtype == `OP_TLBSRCH)
        begin
            idxNext[`IDX_NE] = ~srchHit;
            if (srchHit)
                idxNext[`TLB_IDX_W-1:0] = srchIndex;
        end
        else if (isMmu && subtype == `OP_TLBRD)
        begin
            if (rdEntry.e)
            begin
                idxNext[`IDX_NE] = 1'b0;
                idxNext[`IDX_PS_LSB +: `IDX_PS_W] = `IDX_PS_W'(`PAGE_SHIFT);  // fixed 4 KiB
                ehiNext[31:`EHI_VPPN_LSB] = rdEntry.vppn;
                elo0Next = packElo(rdEntry.page0, rdEntry.g);
                elo1Next = packElo(rdEntry.page1, rdEntry.g);
                asidNext = rdEntry.asid;
            end
            else
            begin
                idxNext  = 32'b0;
                idxNext[`IDX_NE] = 1'b1;
                ehiNext  = 32'b0;
                elo0Next = 32'b0;
                elo1Next = 32'b0;
                asidNext = '0;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            tlbIdxOut  <= '0;
            tlbEhiOut  <= '0;
            tlbElo0Out <= '0;
            tlbElo1Out <= '0;
            asidOut    <= '0;
        end
        else if (!stallW)
        begin
            tlbIdxOut  <= flushW ? 32'b0 : idxNext;
            tlbEhiOut  <= flushW ? 32'b0 : ehiNext;
            tlbElo0Out <= flushW ? 32'b0 : elo0Next;
            tlbElo1Out <= flushW ? 32'b0 : elo1Next;
            asidOut    <= flushW ? '0 : asidNext;
        end
    end

endmodule

// File: tlb/tlbMatch.sv
`timescale 1ns/100ps
`include "mmu_consts.svh"

module tlbMatch
(
    input  mmuPkg::tlbTableT      entries,
    input  logic [`VPPN_W-1:0]    vpn,
    input  logic [`ASID_W-1:0]    asid,
    output logic                  hit,
    output logic [`TLB_IDX_W-1:0] hitIndex
);

    logic [`TLB_ENTRIES-1:0] matchVec;

    always_comb
    begin
        for (int i = 0; i < `TLB_ENTRIES; i++)
        begin
            matchVec[i] = entries[i].e && (entries[i].vppn == vpn) &&
                          (entries[i].g || (entries[i].asid == asid));
        end
    end

    assign hit = |matchVec;

    // highest set bit wins
    always_comb
    begin
        hitIndex = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++)
        begin
            if (matchVec[i])
                hitIndex = i[`TLB_IDX_W-1:0];
        end
    end

    // software keeps the table free of overlapping pages
    always_comb
    begin
        assert ($isunknown(matchVec) || $onehot0(matchVec))
            else $error("multiple TLB entries match vpn %h", vpn);
    end

endmodule

// File: tlb/tlbArray.sv
`timescale 1ns/100ps
`include "mmu_consts.svh"

module tlbArray
(
    input  logic                  clk,
    input  logic                  rstN,
    input  logic [`TLB_IDX_W-1:0] index,
    input  logic                  wrEn,
    input  mmuPkg::tlbEntryT      wrEntry,
    input  logic                  invEn,
    input  logic [1:0]            invOp,
    output mmuPkg::tlbTableT      entries,
    output mmuPkg::tlbEntryT      rdEntry
);
    import mmuPkg::*;

    tlbEntryT                 dataQ [`TLB_ENTRIES];  // e field unused here
    logic [`TLB_ENTRIES-1:0]  eQ;

    always_ff @(posedge clk)
    begin
        if (wrEn)
            dataQ[index] <= wrEntry;
    end

    // existence bits
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            eQ <= '0;
        end
        else if (wrEn)
        begin
            eQ[index] <= wrEntry.e;
        end
        else if (invEn)
        begin
            for (int i = 0; i < `TLB_ENTRIES; i++)
            begin
                case (invOp)
                    2'd0, 2'd1:
                        eQ[i] <= 1'b0;
                    2'd2:
                        if (dataQ[i].g)
                            eQ[i] <= 1'b0;
                    default:
                        if (!dataQ[i].g)  // non-global only
                            eQ[i] <= 1'b0;
                endcase
            end
        end
    end

    always_comb
    begin
        for (int i = 0; i < `TLB_ENTRIES; i++)
        begin
            entries[i]   = dataQ[i];
            entries[i].e = eQ[i];
        end
    end

    assign rdEntry = entries[index];

    // maintenance decode must never issue both in one cycle
    wrInvExclusive: assert property (@(posedge clk) disable iff (!rstN) !(wrEn && invEn))
        else $error("TLB write and invalidate issued together");

endmodule

// File: common/mmuPkg.sv
`include "mmu_consts.svh"

package mmuPkg;

    // one half of a double page
    typedef struct packed
    {
        logic [`PPN_W-1:0] ppn;
        logic [1:0]        plv;
        logic [1:0]        mat;
        logic              d;
        logic              v;
    } tlbPageT;

    typedef struct packed
    {
        logic [`VPPN_W-1:0] vppn;
        logic [`ASID_W-1:0] asid;
        logic               g;
        logic               e;
        tlbPageT            page0;  // even page
        tlbPageT            page1;  // odd page
    } tlbEntryT;

    typedef tlbEntryT [`TLB_ENTRIES-1:0] tlbTableT;

    // valid, subcode, code
    typedef struct packed
    {
        logic       valid;
        logic [8:0] subcode;
        logic [5:0] code;
    } excpArgT;

endpackage

// File: common/mmu_consts.svh
`ifndef MMU_CONSTS_SVH
`define MMU_CONSTS_SVH

// TLB geometry
`define TLB_IDX_W       5
`define TLB_ENTRIES     32
`define VPPN_W          19
`define PPN_W           20
`define ASID_W          10
`define PAGE_SHIFT      12

// CSR bit positions
`define IDX_NE          31
`define IDX_PS_LSB      24
`define IDX_PS_W        6
`define EHI_VPPN_LSB    13
`define ELO_G           6
`define ELO_PPN_LSB     8

`define CRMD_PLV_HI     1
`define CRMD_PLV_LO     0
`define CRMD_DA_BIT     3
`define CRMD_PG_BIT     4
`define CRMD_DATF_HI    6
`define CRMD_DATF_LO    5
`define CRMD_DATM_HI    8
`define CRMD_DATM_LO    7

`define TYPE_MMU        4'd11
`define TYPE_PRIV_MMU   4'd10

`define OP_TLBSRCH      5'd1
`define OP_TLBRD        5'd2
`define OP_TLBWR        5'd3
`define OP_TLBFILL      5'd4
`define OP_INVTLB       5'd5

`define ACC_FETCH       2'd0
`define ACC_LOAD        2'd1
`define ACC_STORE       2'd2

`define EC_PIL          6'h01
`define EC_PIS          6'h02
`define EC_PIF          6'h03
`define EC_PME          6'h04
`define EC_PPI          6'h07
`define EC_ADE          6'h08
`define EC_TLBR         6'h3F

`define ESUB_ADEF       9'h000
`define ESUB_ADEM       9'h001

`endif
